/* hdl/rob_cfg.svh */
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// reorder buffer geometry, tags run 1..ROB_DEPTH and 0 means none
`define ROB_DEPTH 8
`define ROB_TAG_W 4

// datapath and register file
`define XLEN      32
`define REG_ID_W  5
`define NUM_REGS  32

// instruction kinds
`define KIND_W      2
`define KIND_ALU    2'd0
`define KIND_LOAD   2'd1
`define KIND_STORE  2'd2
`define KIND_BRANCH 2'd3

`endif

/* hdl/rob_pkg.sv */
`default_nettype none

`include "rob_cfg.svh"

package rob_pkg;

  // branch view of an alu-bus word
  typedef struct packed {
    logic [`XLEN-3:0] target_hi; // correct next pc, word aligned
    logic             spare;
    logic             taken;
  } branch_outcome_s;

  // alu-bus word, meaning picked by the kind held in the entry
  typedef union packed {
    logic [`XLEN-1:0] value;
    branch_outcome_s  branch;
  } result_word_u;

endpackage

`default_nettype wire

/* hdl/dispatch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module dispatch_unit (
  input  wire logic                 clk,
  input  wire logic                 is_any_reset,
  input  wire logic                 flush,
  input  wire logic                 in_valid,
  input  wire logic [`KIND_W-1:0]   in_kind,
  input  wire logic [`REG_ID_W-1:0] in_rd,
  input  wire logic [`REG_ID_W-1:0] in_rs1,
  input  wire logic [`REG_ID_W-1:0] in_rs2,
  input  wire logic [`XLEN-1:0]     in_pc,
  input  wire logic [`XLEN-1:0]     in_pred_next_pc,
  input  wire logic                 rob_full,
  input  wire logic [`ROB_TAG_W-1:0] alloc_tag,
  input  wire logic                 vj_ready,
  input  wire logic [`XLEN-1:0]     vj,
  input  wire logic                 vk_ready,
  input  wire logic [`XLEN-1:0]     vk,
  input  wire logic [`XLEN-1:0]     rs1_data,
  input  wire logic [`XLEN-1:0]     rs2_data,
  input  wire logic                 commit_valid,
  input  wire logic [`ROB_TAG_W-1:0] commit_tag,
  input  wire logic [`REG_ID_W-1:0] commit_rd,
  output logic                      in_ready,
  output logic                      alloc_valid,
  output logic [`KIND_W-1:0]        alloc_kind,
  output logic [`REG_ID_W-1:0]      alloc_rd,
  output logic [`XLEN-1:0]          alloc_pc,
  output logic [`XLEN-1:0]          alloc_pred_next_pc,
  output logic [`ROB_TAG_W-1:0]     qj,
  output logic [`ROB_TAG_W-1:0]     qk,
  output logic [`REG_ID_W-1:0]      rs1,
  output logic [`REG_ID_W-1:0]      rs2,
  output logic                      disp_valid,
  output logic [`ROB_TAG_W-1:0]     disp_tag,
  output logic [`XLEN-1:0]          disp_vj,
  output logic [`ROB_TAG_W-1:0]     disp_vj_tag,
  output logic [`XLEN-1:0]          disp_vk,
  output logic [`ROB_TAG_W-1:0]     disp_vk_tag
);

  logic                  held_valid;
  logic [`KIND_W-1:0]    held_kind;
  logic [`REG_ID_W-1:0]  held_rd;
  logic [`REG_ID_W-1:0]  held_rs1;
  logic [`REG_ID_W-1:0]  held_rs2;
  logic [`XLEN-1:0]      held_pc;
  logic [`XLEN-1:0]      held_pred_next_pc;
  logic [`ROB_TAG_W-1:0] rename_tag [0:`NUM_REGS-1]; // newest in-flight writer
  logic [`ROB_TAG_W-1:0] raw_qj;
  logic [`ROB_TAG_W-1:0] raw_qk;
  logic                  writes_rd;
  logic [`XLEN-1:0]      op_j;
  logic [`XLEN-1:0]      op_k;
  logic [`ROB_TAG_W-1:0] op_j_tag;
  logic [`ROB_TAG_W-1:0] op_k_tag;

  assign alloc_valid        = held_valid && !rob_full;
  assign in_ready           = !held_valid || alloc_valid;
  assign alloc_kind         = held_kind;
  assign alloc_rd           = held_rd;
  assign alloc_pc           = held_pc;
  assign alloc_pred_next_pc = held_pred_next_pc;
  assign rs1                = held_rs1;
  assign rs2                = held_rs2;

  assign writes_rd = (held_rd != '0) &&
                     (held_kind == `KIND_ALU || held_kind == `KIND_LOAD);

  // a tag committing right now is already in the register file
  assign raw_qj = rename_tag[held_rs1];
  assign raw_qk = rename_tag[held_rs2];
  assign qj = (commit_valid && raw_qj == commit_tag) ? '0 : raw_qj;
  assign qk = (commit_valid && raw_qk == commit_tag) ? '0 : raw_qk;

  always_comb begin
    op_j     = '0;
    op_j_tag = '0;
    if (qj == '0) op_j = rs1_data;
    else if (vj_ready) op_j = vj;
    else op_j_tag = qj; // wait on producer
    op_k     = '0;
    op_k_tag = '0;
    if (qk == '0) op_k = rs2_data;
    else if (vk_ready) op_k = vk;
    else op_k_tag = qk;
  end

  always_ff @(posedge clk) begin
    if (is_any_reset || flush) begin
      held_valid <= 1'b0; // younger than the redirecting branch
      disp_valid <= 1'b0;
    end else begin
      if (in_valid && in_ready) held_valid <= 1'b1;
      else if (alloc_valid) held_valid <= 1'b0;
      disp_valid <= alloc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      held_kind         <= in_kind;
      held_rd           <= in_rd;
      held_rs1          <= in_rs1;
      held_rs2          <= in_rs2;
      held_pc           <= in_pc;
      held_pred_next_pc <= in_pred_next_pc;
    end
    if (alloc_valid) begin
      disp_tag    <= alloc_tag;
      disp_vj     <= op_j;
      disp_vj_tag <= op_j_tag;
      disp_vk     <= op_k;
      disp_vk_tag <= op_k_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (is_any_reset || flush) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        rename_tag[i] <= '0;
      end
    end else begin
      if (commit_valid && rename_tag[commit_rd] == commit_tag) begin
        rename_tag[commit_rd] <= '0;
      end
      // a new writer overrides the clear
      if (alloc_valid && writes_rd) rename_tag[held_rd] <= alloc_tag;
    end
  end

  // tags from the buffer stay in 1..ROB_DEPTH
  a_alloc_tag_valid: assert property (@(posedge clk) disable iff (is_any_reset)
    alloc_valid |-> (alloc_tag != '0 && alloc_tag <= `ROB_DEPTH));

endmodule

`default_nettype wire

/* hdl/reorder_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module reorder_buffer (
  input  wire logic                  clk,
  input  wire logic                  is_any_reset,
  input  wire logic                  flush,
  input  wire logic                  alloc_valid,
  input  wire logic [`KIND_W-1:0]    alloc_kind,
  input  wire logic [`REG_ID_W-1:0]  alloc_rd,
  input  wire logic [`XLEN-1:0]      alloc_pc,
  input  wire logic [`XLEN-1:0]      alloc_pred_next_pc,
  input  wire logic [`ROB_TAG_W-1:0] qj,
  input  wire logic [`ROB_TAG_W-1:0] qk,
  input  wire logic [`ROB_TAG_W-1:0] ld_tag,
  input  wire logic [`XLEN-1:0]      ld_value,
  input  wire logic [`ROB_TAG_W-1:0] alu_tag,
  input  wire rob_pkg::result_word_u alu_result,
  output logic                       rob_full,
  output logic [`ROB_TAG_W-1:0]      alloc_tag,
  output logic                       vj_ready,
  output logic [`XLEN-1:0]           vj,
  output logic                       vk_ready,
  output logic [`XLEN-1:0]           vk,
  output logic                       ret_valid,
  output logic [`ROB_TAG_W-1:0]      ret_tag,
  output logic [`KIND_W-1:0]         ret_kind,
  output logic [`REG_ID_W-1:0]       ret_rd,
  output rob_pkg::result_word_u      ret_value,
  output logic [`XLEN-1:0]           ret_pc,
  output logic [`XLEN-1:0]           ret_pred_next_pc
);

  import rob_pkg::*;

  logic [`ROB_TAG_W-1:0] head;
  logic [`ROB_TAG_W-1:0] tail;
  logic [`ROB_TAG_W-1:0] count;
  logic                  head_ready;

  logic [`KIND_W-1:0]    entry_kind    [1:`ROB_DEPTH];
  logic                  entry_done    [1:`ROB_DEPTH];
  logic [`REG_ID_W-1:0]  entry_rd      [1:`ROB_DEPTH];
  logic [`XLEN-1:0]      entry_pc      [1:`ROB_DEPTH];
  logic [`XLEN-1:0]      entry_pred_pc [1:`ROB_DEPTH];
  result_word_u          entry_result  [1:`ROB_DEPTH];

  function automatic logic [`ROB_TAG_W-1:0] next_slot(input logic [`ROB_TAG_W-1:0] slot);
    return (slot == `ROB_DEPTH) ? `ROB_TAG_W'd1 : slot + `ROB_TAG_W'd1;
  endfunction

  // ready bit on top of the operand value
  function automatic logic [`XLEN:0] lookup(input logic [`ROB_TAG_W-1:0] q);
    logic [`XLEN:0] found;
    found = '0;
    if (q != '0) begin
      if (entry_done[q]) found = {1'b1, entry_result[q].value};
      else if (ld_tag == q) found = {1'b1, ld_value}; // same-cycle bypass
      else if (alu_tag == q) found = {1'b1, alu_result.value};
    end
    return found;
  endfunction

  // true when tag sits between head and tail and has no result yet
  function automatic logic awaiting(input logic [`ROB_TAG_W-1:0] t);
    logic [`ROB_TAG_W-1:0] offset;
    offset = (t >= head) ? t - head : t + `ROB_DEPTH - head;
    return (t != '0) && (t <= `ROB_DEPTH) && (offset < count) && !entry_done[t];
  endfunction

  assign rob_full  = count >= `ROB_DEPTH - 1; // pre-full, one spare slot
  assign alloc_tag = tail;

  // stores carry no result
  assign head_ready = (count != '0) &&
                      (entry_done[head] || entry_kind[head] == `KIND_STORE);

  always_comb begin
    {vj_ready, vj} = lookup(qj);
    {vk_ready, vk} = lookup(qk);
  end

  always_ff @(posedge clk) begin
    if (is_any_reset || flush) begin
      head      <= `ROB_TAG_W'd1;
      tail      <= `ROB_TAG_W'd1;
      count     <= '0;
      ret_valid <= 1'b0;
      for (int i = 1; i <= `ROB_DEPTH; i++) begin
        entry_done[i] <= 1'b0;
      end
    end else begin
      if (alloc_valid) begin
        tail             <= next_slot(tail);
        entry_done[tail] <= 1'b0;
      end
      if (ld_tag != '0) entry_done[ld_tag] <= 1'b1;
      if (alu_tag != '0) entry_done[alu_tag] <= 1'b1;
      ret_valid <= head_ready;
      if (head_ready) head <= next_slot(head);
      count <= count + alloc_valid - head_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid) begin
      entry_kind[tail]    <= alloc_kind;
      entry_rd[tail]      <= alloc_rd;
      entry_pc[tail]      <= alloc_pc;
      entry_pred_pc[tail] <= alloc_pred_next_pc;
    end
    if (ld_tag != '0) entry_result[ld_tag].value <= ld_value;
    if (alu_tag != '0) entry_result[alu_tag] <= alu_result;
    if (head_ready) begin
      ret_tag          <= head;
      ret_kind         <= entry_kind[head];
      ret_rd           <= entry_rd[head];
      ret_value        <= entry_result[head];
      ret_pc           <= entry_pc[head];
      ret_pred_next_pc <= entry_pred_pc[head];
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (is_any_reset)
    count <= `ROB_DEPTH);

  a_ld_in_flight: assert property (@(posedge clk) disable iff (is_any_reset || flush)
    ld_tag != '0 |-> awaiting(ld_tag));

  a_alu_in_flight: assert property (@(posedge clk) disable iff (is_any_reset || flush)
    alu_tag != '0 |-> awaiting(alu_tag));

endmodule

`default_nettype wire

/* hdl/commit_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module commit_unit (
  input  wire logic                  clk,
  input  wire logic                  is_any_reset,
  input  wire logic                  ret_valid,
  input  wire logic [`ROB_TAG_W-1:0] ret_tag,
  input  wire logic [`KIND_W-1:0]    ret_kind,
  input  wire logic [`REG_ID_W-1:0]  ret_rd,
  input  wire rob_pkg::result_word_u ret_value,
  input  wire logic [`XLEN-1:0]      ret_pc,
  input  wire logic [`XLEN-1:0]      ret_pred_next_pc,
  input  wire logic [`REG_ID_W-1:0]  rs1,
  input  wire logic [`REG_ID_W-1:0]  rs2,
  output logic [`XLEN-1:0]           rs1_data,
  output logic [`XLEN-1:0]           rs2_data,
  output logic                       commit_valid,
  output logic [`ROB_TAG_W-1:0]      commit_tag,
  output logic [`REG_ID_W-1:0]       commit_rd,
  output logic [`XLEN-1:0]           commit_value,
  output logic [`ROB_TAG_W-1:0]      store_commit_tag,
  output logic                       redirect,
  output logic [`XLEN-1:0]           redirect_pc,
  output logic                       br_valid,
  output logic                       br_taken
);

  import rob_pkg::*;

  logic [`XLEN-1:0] regs [1:`NUM_REGS-1]; // x0 is not stored
  branch_outcome_s  ret_branch;
  logic [`XLEN-1:0] correct_next_pc;
  logic             ret_live;
  logic             writes_rd;

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  assign ret_branch      = ret_value.branch;
  assign correct_next_pc = {ret_branch.target_hi, 2'b00};

  // the retirement right behind a redirect is on the wrong path
  assign ret_live  = ret_valid && !redirect;
  assign writes_rd = ret_kind == `KIND_ALU || ret_kind == `KIND_LOAD;

  always_ff @(posedge clk) begin
    if (is_any_reset) begin
      commit_valid     <= 1'b0;
      store_commit_tag <= '0;
      redirect         <= 1'b0;
      br_valid         <= 1'b0;
      for (int i = 1; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      commit_valid     <= ret_live && writes_rd;
      store_commit_tag <= (ret_live && ret_kind == `KIND_STORE) ? ret_tag : '0;
      br_valid         <= ret_live && ret_kind == `KIND_BRANCH;
      redirect         <= ret_live && ret_kind == `KIND_BRANCH &&
                          correct_next_pc != ret_pred_next_pc;
      if (ret_live && writes_rd && ret_rd != '0) regs[ret_rd] <= ret_value.value;
    end
  end

  always_ff @(posedge clk) begin
    if (ret_live) begin
      commit_tag   <= ret_tag;
      commit_rd    <= ret_rd;
      commit_value <= ret_value.value;
      redirect_pc  <= correct_next_pc;
      br_taken     <= correct_next_pc != ret_pc + `XLEN'd4;
    end
  end

  // the flush stops retirement right after a redirect
  a_flush_stops_retire: assert property (@(posedge clk) disable iff (is_any_reset)
    redirect |=> !ret_valid);

endmodule

`default_nettype wire

/* hdl/rob_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module rob_subsystem (
  input  wire logic                  clk,
  input  wire logic                  is_any_reset,
  input  wire logic                  in_valid,
  input  wire logic [`KIND_W-1:0]    in_kind,
  input  wire logic [`REG_ID_W-1:0]  in_rd,
  input  wire logic [`REG_ID_W-1:0]  in_rs1,
  input  wire logic [`REG_ID_W-1:0]  in_rs2,
  input  wire logic [`XLEN-1:0]      in_pc,
  input  wire logic [`XLEN-1:0]      in_pred_next_pc,
  output wire logic                  in_ready,
  input  wire logic [`ROB_TAG_W-1:0] ld_tag,
  input  wire logic [`XLEN-1:0]      ld_value,
  input  wire logic [`ROB_TAG_W-1:0] alu_tag,
  input  wire rob_pkg::result_word_u alu_result,
  output wire logic                  disp_valid,
  output wire logic [`ROB_TAG_W-1:0] disp_tag,
  output wire logic [`XLEN-1:0]      disp_vj,
  output wire logic [`ROB_TAG_W-1:0] disp_vj_tag,
  output wire logic [`XLEN-1:0]      disp_vk,
  output wire logic [`ROB_TAG_W-1:0] disp_vk_tag,
  output wire logic                  commit_valid,
  output wire logic [`ROB_TAG_W-1:0] commit_tag,
  output wire logic [`REG_ID_W-1:0]  commit_rd,
  output wire logic [`XLEN-1:0]      commit_value,
  output wire logic [`ROB_TAG_W-1:0] store_commit_tag,
  output wire logic                  redirect,
  output wire logic [`XLEN-1:0]      redirect_pc,
  output wire logic                  br_valid,
  output wire logic                  br_taken
);

  import rob_pkg::*;

  wire logic                  alloc_valid;
  wire logic [`KIND_W-1:0]    alloc_kind;
  wire logic [`REG_ID_W-1:0]  alloc_rd;
  wire logic [`XLEN-1:0]      alloc_pc;
  wire logic [`XLEN-1:0]      alloc_pred_next_pc;
  wire logic [`ROB_TAG_W-1:0] alloc_tag;
  wire logic                  rob_full;
  wire logic [`ROB_TAG_W-1:0] qj;
  wire logic [`ROB_TAG_W-1:0] qk;
  wire logic                  vj_ready;
  wire logic [`XLEN-1:0]      vj;
  wire logic                  vk_ready;
  wire logic [`XLEN-1:0]      vk;
  wire logic [`REG_ID_W-1:0]  rs1;
  wire logic [`REG_ID_W-1:0]  rs2;
  wire logic [`XLEN-1:0]      rs1_data;
  wire logic [`XLEN-1:0]      rs2_data;
  wire logic                  ret_valid;
  wire logic [`ROB_TAG_W-1:0] ret_tag;
  wire logic [`KIND_W-1:0]    ret_kind;
  wire logic [`REG_ID_W-1:0]  ret_rd;
  wire result_word_u          ret_value;
  wire logic [`XLEN-1:0]      ret_pc;
  wire logic [`XLEN-1:0]      ret_pred_next_pc;

  dispatch_unit u_dispatch (
    .clk, .is_any_reset, .flush(redirect),
    .in_valid, .in_kind, .in_rd, .in_rs1, .in_rs2, .in_pc, .in_pred_next_pc,
    .rob_full, .alloc_tag, .vj_ready, .vj, .vk_ready, .vk, .rs1_data, .rs2_data,
    .commit_valid, .commit_tag, .commit_rd, .in_ready,
    .alloc_valid, .alloc_kind, .alloc_rd, .alloc_pc, .alloc_pred_next_pc,
    .qj, .qk, .rs1, .rs2,
    .disp_valid, .disp_tag, .disp_vj, .disp_vj_tag, .disp_vk, .disp_vk_tag
  );

  reorder_buffer u_rob (
    .clk, .is_any_reset, .flush(redirect),
    .alloc_valid, .alloc_kind, .alloc_rd, .alloc_pc, .alloc_pred_next_pc,
    .qj, .qk, .ld_tag, .ld_value, .alu_tag, .alu_result,
    .rob_full, .alloc_tag, .vj_ready, .vj, .vk_ready, .vk,
    .ret_valid, .ret_tag, .ret_kind, .ret_rd, .ret_value, .ret_pc, .ret_pred_next_pc
  );

  commit_unit u_commit (
    .clk, .is_any_reset,
    .ret_valid, .ret_tag, .ret_kind, .ret_rd, .ret_value, .ret_pc, .ret_pred_next_pc,
    .rs1, .rs2, .rs1_data, .rs2_data,
    .commit_valid, .commit_tag, .commit_rd, .commit_value, .store_commit_tag,
    .redirect, .redirect_pc, .br_valid, .br_taken
  );

endmodule

`default_nettype wire

/* verification/rob_subsystem_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_cfg.svh"

module rob_subsystem_tb;

  import rob_pkg::*;

  localparam int MAX_LINES = 64;
  localparam int STALL_LIMIT = 300;
  localparam int RUN_LIMIT = 4000;

  logic                  clk;
  logic                  is_any_reset;
  logic                  in_valid;
  logic [`KIND_W-1:0]    in_kind;
  logic [`REG_ID_W-1:0]  in_rd;
  logic [`REG_ID_W-1:0]  in_rs1;
  logic [`REG_ID_W-1:0]  in_rs2;
  logic [`XLEN-1:0]      in_pc;
  logic [`XLEN-1:0]      in_pred_next_pc;
  logic                  in_ready;
  logic [`ROB_TAG_W-1:0] ld_tag;
  logic [`XLEN-1:0]      ld_value;
  logic [`ROB_TAG_W-1:0] alu_tag;
  result_word_u          alu_result;
  logic                  disp_valid;
  logic [`ROB_TAG_W-1:0] disp_tag;
  logic [`XLEN-1:0]      disp_vj;
  logic [`ROB_TAG_W-1:0] disp_vj_tag;
  logic [`XLEN-1:0]      disp_vk;
  logic [`ROB_TAG_W-1:0] disp_vk_tag;
  logic                  commit_valid;
  logic [`ROB_TAG_W-1:0] commit_tag;
  logic [`REG_ID_W-1:0]  commit_rd;
  logic [`XLEN-1:0]      commit_value;
  logic [`ROB_TAG_W-1:0] store_commit_tag;
  logic                  redirect;
  logic [`XLEN-1:0]      redirect_pc;
  logic                  br_valid;
  logic                  br_taken;

  // one entry per line of the data file
  string                 t_name   [MAX_LINES];
  logic [`KIND_W-1:0]    t_kind   [MAX_LINES];
  logic [`REG_ID_W-1:0]  t_rd     [MAX_LINES];
  logic [`REG_ID_W-1:0]  t_rs1    [MAX_LINES];
  logic [`REG_ID_W-1:0]  t_rs2    [MAX_LINES];
  logic [`XLEN-1:0]      t_pc     [MAX_LINES];
  logic [`XLEN-1:0]      t_pred   [MAX_LINES];
  logic [`XLEN-1:0]      t_result [MAX_LINES];
  int                    t_delay  [MAX_LINES];
  logic [`ROB_TAG_W-1:0] t_tag    [MAX_LINES];
  int                    t_due    [MAX_LINES];
  int                    t_ret    [MAX_LINES]; // cycle the result went out or -1
  bit                    t_wrong  [MAX_LINES];

  int                    acc_q[$];   // accepted but not yet reported
  int                    order_q[$]; // awaiting commit in program order
  int                    pend_q[$];  // results still to return
  int                    last_writer [`NUM_REGS];
  logic [`XLEN-1:0]      model_regs  [`NUM_REGS];
  logic [`ROB_TAG_W-1:0] next_tag;
  bit                    shadow;     // behind a mispredicted branch
  int                    n_lines;
  int                    li;
  int                    cyc;
  int                    mismatches;
  int                    failures;
  int                    bp_cycles;

  rob_subsystem DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic complain(input string msg);
    failures++;
    $display("error: %s", msg);
  endtask

  task automatic check_word(input string name, input string what,
                            input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input string what,
                           input logic [`ROB_TAG_W-1:0] exp, input logic [`ROB_TAG_W-1:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch %s %s: expected %0d, actual %0d", name, what, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input string what,
                           input logic [`REG_ID_W-1:0] exp, input logic [`REG_ID_W-1:0] act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch %s %s: expected x%0d, actual x%0d", name, what, exp, act);
    end
  endtask

  task automatic check_result(input string name, input string what,
                              input result_word_u exp, input result_word_u act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  task automatic load_testdata();
    int fd;
    int got;
    string line;
    string name;
    int kind;
    int rd;
    int rs1;
    int rs2;
    int delay;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pred;
    logic [`XLEN-1:0] res;
    n_lines = 0;
    fd = $fopen("verification/rob_testdata.txt", "r");
    if (fd == 0) begin
      complain("cannot open verification/rob_testdata.txt");
      return;
    end
    while (!$feof(fd) && n_lines < MAX_LINES) begin
      line = "";
      got = $fgets(line, fd);
      if (line.len() > 1 && line[0] != "#") begin
        got = $sscanf(line, "%s %d %d %d %d %h %h %h %d",
                      name, kind, rd, rs1, rs2, pc, pred, res, delay);
        if (got == 9) begin
          t_name[n_lines]   = name;
          t_kind[n_lines]   = kind;
          t_rd[n_lines]     = rd;
          t_rs1[n_lines]    = rs1;
          t_rs2[n_lines]    = rs2;
          t_pc[n_lines]     = pc;
          t_pred[n_lines]   = pred;
          t_result[n_lines] = res;
          t_delay[n_lines]  = delay;
          t_ret[n_lines]    = -1;
          n_lines++;
        end
      end
    end
    $fclose(fd);
  endtask

  // ready when the newest writer's result went out by the allocation cycle
  task automatic check_operand(input int idx, input string what,
                               input logic [`REG_ID_W-1:0] r,
                               input logic [`XLEN-1:0] val, input logic [`ROB_TAG_W-1:0] tag);
    int w;
    w = (r == 0) ? -1 : last_writer[r];
    if (w >= 0 && (t_ret[w] < 0 || t_ret[w] > cyc - 1)) begin
      check_tag(t_name[idx], {what, " tag"}, t_tag[w], tag);
    end else begin
      check_tag(t_name[idx], {what, " tag"}, '0, tag);
      check_word(t_name[idx], what, (w >= 0) ? t_result[w] : model_regs[r], val);
    end
  endtask

  task automatic flush_model();
    acc_q.delete();
    order_q.delete();
    pend_q.delete();
    for (int r = 0; r < `NUM_REGS; r++) last_writer[r] = -1;
    next_tag = 1;
  endtask

  task automatic drive();
    int k;
    int idx;
    ld_tag     = '0;
    ld_value   = '0;
    alu_tag    = '0;
    alu_result = '0;
    k = 0;
    while (k < pend_q.size()) begin
      idx = pend_q[k];
      if (t_due[idx] <= cyc && t_kind[idx] == `KIND_LOAD && ld_tag == '0) begin
        ld_tag   = t_tag[idx];
        ld_value = t_result[idx];
        t_ret[idx] = cyc;
        pend_q.delete(k);
      end else if (t_due[idx] <= cyc && t_kind[idx] != `KIND_LOAD && alu_tag == '0) begin
        alu_tag          = t_tag[idx];
        alu_result.value = t_result[idx];
        t_ret[idx] = cyc;
        pend_q.delete(k);
      end else begin
        k++;
      end
    end
    in_valid = 1'b0;
    if (li < n_lines && t_name[li] != "drain") begin
      in_valid        = 1'b1;
      in_kind         = t_kind[li];
      in_rd           = t_rd[li];
      in_rs1          = t_rs1[li];
      in_rs2          = t_rs2[li];
      in_pc           = t_pc[li];
      in_pred_next_pc = t_pred[li];
    end
  endtask

  task automatic observe();
    int idx;
    logic [`XLEN-1:0] target;
    result_word_u exp_br;
    result_word_u act_br;
    if (disp_valid) begin
      if (acc_q.size() == 0) begin
        complain("dispatch report with no accepted instruction");
      end else begin
        idx = acc_q.pop_front();
        check_tag(t_name[idx], "disp_tag", next_tag, disp_tag);
        t_tag[idx] = disp_tag;
        next_tag = (next_tag == `ROB_DEPTH) ? 1 : next_tag + 1;
        check_operand(idx, "vj", t_rs1[idx], disp_vj, disp_vj_tag);
        check_operand(idx, "vk", t_rs2[idx], disp_vk, disp_vk_tag);
        if ((t_kind[idx] == `KIND_ALU || t_kind[idx] == `KIND_LOAD) && t_rd[idx] != 0)
          last_writer[t_rd[idx]] = idx;
        order_q.push_back(idx);
        t_due[idx] = cyc + t_delay[idx];
        if (t_kind[idx] != `KIND_STORE) pend_q.push_back(idx); // stores need no result
      end
    end
    if (in_valid && in_ready) begin
      acc_q.push_back(li);
      t_wrong[li] = shadow;
      if (t_kind[li] == `KIND_BRANCH && {t_result[li][`XLEN-1:2], 2'b00} != t_pred[li])
        shadow = 1'b1;
      li++;
    end else if (in_valid) begin
      bp_cycles++;
    end
    if (commit_valid || store_commit_tag != '0 || br_valid) begin
      if (order_q.size() == 0) begin
        complain("commit output with nothing in flight");
      end else begin
        idx = order_q.pop_front();
        if (t_wrong[idx]) complain({t_name[idx], " committed from the wrong path"});
        if (commit_valid) begin
          if (t_kind[idx] != `KIND_ALU && t_kind[idx] != `KIND_LOAD)
            complain({t_name[idx], " committed as a register write"});
          check_tag(t_name[idx], "commit_tag", t_tag[idx], commit_tag);
          check_reg(t_name[idx], "commit_rd", t_rd[idx], commit_rd);
          check_word(t_name[idx], "commit_value", t_result[idx], commit_value);
          if (t_rd[idx] != 0) model_regs[t_rd[idx]] = t_result[idx];
        end else if (store_commit_tag != '0) begin
          if (t_kind[idx] != `KIND_STORE) complain({t_name[idx], " reported as a store"});
          check_tag(t_name[idx], "store_commit_tag", t_tag[idx], store_commit_tag);
        end else begin
          if (t_kind[idx] != `KIND_BRANCH) complain({t_name[idx], " reported as a branch"});
          target = {t_result[idx][`XLEN-1:2], 2'b00};
          exp_br.branch.target_hi = target[`XLEN-1:2];
          exp_br.branch.spare     = 1'b0;
          exp_br.branch.taken     = target != t_pc[idx] + 4;
          act_br.branch.target_hi = redirect_pc[`XLEN-1:2];
          act_br.branch.spare     = 1'b0;
          act_br.branch.taken     = br_taken;
          check_result(t_name[idx], "branch outcome", exp_br, act_br);
          check_word(t_name[idx], "redirect_pc", target, redirect_pc);
          check_word(t_name[idx], "redirect", target != t_pred[idx], redirect);
          if (redirect) flush_model();
        end
      end
    end else if (redirect) begin
      complain("redirect without a branch commit");
    end
  endtask

  initial begin
    int stalled;
    int idle;
    bit aborted;
    is_any_reset    = 1'b1;
    in_valid        = 1'b0;
    in_kind         = '0;
    in_rd           = '0;
    in_rs1          = '0;
    in_rs2          = '0;
    in_pc           = '0;
    in_pred_next_pc = '0;
    ld_tag          = '0;
    ld_value        = '0;
    alu_tag         = '0;
    alu_result      = '0;
    mismatches = 0;
    failures   = 0;
    bp_cycles  = 0;
    li         = 0;
    cyc        = 0;
    shadow     = 1'b0;
    stalled    = 0;
    idle       = 0;
    aborted    = 1'b0;
    for (int r = 0; r < `NUM_REGS; r++) model_regs[r] = '0;
    flush_model();
    load_testdata();

    repeat (3) @(posedge clk);
    #2 is_any_reset = 1'b0;
    @(negedge clk);
    if (in_ready !== 1'b1) complain("in_ready low after reset");
    if (disp_valid || commit_valid || redirect || br_valid || store_commit_tag != '0)
      complain("report or commit output active after reset");

    while (!aborted && idle < 8) begin
      @(posedge clk);
      #2;
      cyc++;
      drive();
      @(negedge clk);
      observe();
      if (in_valid) stalled++; // cleared below on a transfer
      if (li < n_lines && t_name[li] == "drain") begin
        if (acc_q.size() == 0 && order_q.size() == 0 && pend_q.size() == 0) begin
          li++;
          shadow  = 1'b0;
          stalled = 0;
        end else begin
          stalled++;
        end
      end else if (!in_valid || !in_ready) begin
        stalled = in_valid ? stalled : 0;
      end
      if (in_valid && in_ready) stalled = 0;
      if (stalled > STALL_LIMIT) begin
        complain($sformatf("timeout at line %0d, stream or commits stopped", li));
        aborted = 1'b1;
      end
      if (cyc > RUN_LIMIT) begin
        complain("timeout, run did not finish");
        aborted = 1'b1;
      end
      if (li >= n_lines && order_q.size() == 0 && acc_q.size() == 0) idle++;
    end

    if (bp_cycles == 0) complain("rob_full never held back the input stream");
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/rob_testdata.txt */
# name kind rd rs1 rs2 pc pred_next_pc result delay (pc, pred and result in hex)
# kind 0 alu, 1 load, 2 store, 3 branch; a drain line waits until everything commits
ord_a   1 1 0 0 00000100 00000104 11111111 9
ord_b   0 2 0 0 00000104 00000108 22222222 7
ord_c   0 3 0 0 00000108 0000010c 33333333 1
ord_d   1 4 0 0 0000010c 00000110 44444444 1
dep_tag 0 5 1 2 00000110 00000114 55555555 2
dep_fin 0 6 4 3 00000114 00000118 66666666 1
drain   0 0 0 0 00000000 00000000 00000000 0
dep_rf  0 7 1 6 00000118 0000011c 77777777 1
st_a    2 0 7 5 0000011c 00000120 00000000 0
br_nt   3 0 7 0 00000120 00000124 00000124 2
st_b    2 0 2 3 00000124 00000128 00000000 0
br_tk   3 0 1 0 00000128 00000200 00000201 1
drain   0 0 0 0 00000000 00000000 00000000 0
br_mis  3 0 2 0 00000200 00000204 00000301 6
wp_a    0 8 0 0 00000204 00000208 0000dead 1
wp_b    1 1 0 0 00000208 0000020c 0000beef 1
drain   0 0 0 0 00000000 00000000 00000000 0
after   0 9 1 8 00000300 00000304 99999999 1
bp_0    1 10 9 0 00000304 00000308 a0000000 12
bp_1    0 11 10 0 00000308 0000030c a1111111 12
bp_2    1 12 11 1 0000030c 00000310 a2222222 12
bp_3    0 13 12 0 00000310 00000314 a3333333 12
bp_4    0 14 13 2 00000314 00000318 a4444444 12
bp_5    1 15 14 0 00000318 0000031c a5555555 12
bp_6    0 16 15 3 0000031c 00000320 a6666666 12
bp_7    0 17 16 0 00000320 00000324 a7777777 12
bp_8    1 18 17 4 00000324 00000328 a8888888 12
bp_9    0 19 18 10 00000328 0000032c a9999999 12
drain   0 0 0 0 00000000 00000000 00000000 0

/* vlog.f */
+incdir+hdl
hdl/rob_pkg.sv
hdl/dispatch_unit.sv
hdl/reorder_buffer.sv
hdl/commit_unit.sv
hdl/rob_subsystem.sv
verification/rob_subsystem_tb.sv
